// ==== design/dataMemPkg.sv ====
package dataMemPkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------

    // one data word
    localparam int DATA_WIDTH = 32;

    // byte address into 128 KiB
    localparam int ADDR_WIDTH = 17;

    // byte lanes per word, one bank each
    localparam int LANES = 4;

    // row index inside a single bank
    localparam int ROW_WIDTH = ADDR_WIDTH - 2;

    // --------------------------------------------------
    // types
    // --------------------------------------------------

    // funct3 load/store size codes, other values are undefined
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } memSize_e;

    // one access as presented by the core
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        memSize_e              size;
        logic [DATA_WIDTH-1:0] wdata;
        logic                  write;
    } memReq_t;

    // what a single byte bank needs for one cycle
    typedef struct packed {
        logic [ROW_WIDTH-1:0] row;
        logic [7:0]           data;
        logic                 en;
    } laneWrite_t;

endpackage

// ==== design/storeAligner.sv ====
`timescale 1ns/1ps

module storeAligner (
    input  dataMemPkg::memReq_t                        req,
    output dataMemPkg::laneWrite_t [dataMemPkg::LANES-1:0] lanes
);

    import dataMemPkg::*;

    // --------------------------------------------------
    // address split
    // --------------------------------------------------

    logic [ROW_WIDTH-1:0] baseRow;
    logic [ROW_WIDTH-1:0] nextRow;
    logic [1:0]           offset;

    assign baseRow = req.addr[ADDR_WIDTH-1:2];
    assign offset  = req.addr[1:0];

    // wraps to row zero past the top of the bank
    assign nextRow = baseRow + ROW_WIDTH'(1);

    // --------------------------------------------------
    // access width
    // --------------------------------------------------

    logic [2:0] numBytes;

    // unsigned load codes and undefined codes store nothing
    always_comb begin
        case (req.size)
            SIZE_B:  numBytes = 3'd1;
            SIZE_H:  numBytes = 3'd2;
            SIZE_W:  numBytes = 3'd4;
            default: numBytes = 3'd0;
        endcase
    end

    // --------------------------------------------------
    // lane mapping
    // --------------------------------------------------

    logic [LANES-1:0][7:0] storeBytes;
    logic [LANES-1:0][1:0] byteSel;
    logic [LANES-1:0]      wrapRow;
    logic [LANES-1:0]      covered;

    assign storeBytes = req.wdata;

    for (genvar i = 0; i < LANES; i++) begin : g_lane

        // lane i carries store byte (i - offset) mod 4
        assign byteSel[i] = 2'(i) - offset;

        // lanes below the offset belong to the following row
        assign wrapRow[i] = 2'(i) < offset;

        // only bytes inside the access width are written
        assign covered[i] = {1'b0, byteSel[i]} < numBytes;

        // read and write share the same row
        assign lanes[i].row  = wrapRow[i] ? nextRow : baseRow;
        assign lanes[i].data = storeBytes[byteSel[i]];
        assign lanes[i].en   = req.write & covered[i];

    end

endmodule

// ==== design/byteBank.sv ====
`timescale 1ns/1ps

module byteBank (
    input  logic                   clk,
    input  dataMemPkg::laneWrite_t lane,
    output logic [7:0]             rbyte
);

    import dataMemPkg::*;

    // --------------------------------------------------
    // storage
    // --------------------------------------------------

    // one byte of every word row
    logic [7:0] mem [2**ROW_WIDTH];

    // --------------------------------------------------
    // write port
    // --------------------------------------------------

    // commits on the rising edge while en is high
    always_ff @(posedge clk) begin
        if (lane.en) begin
            mem[lane.row] <= lane.data;
        end
    end

    // --------------------------------------------------
    // read port
    // --------------------------------------------------

    // asynchronous, so a store is visible the cycle after it lands
    assign rbyte = mem[lane.row];

endmodule

// ==== design/loadExtender.sv ====
`timescale 1ns/1ps

module loadExtender (
    input  logic [dataMemPkg::LANES-1:0][7:0]   bytes,
    input  logic [1:0]                          offset,
    input  dataMemPkg::memSize_e                size,
    output logic [dataMemPkg::DATA_WIDTH-1:0]   rdata
);

    import dataMemPkg::*;

    // --------------------------------------------------
    // lane to address order
    // --------------------------------------------------

    logic [LANES-1:0][1:0] laneSel;
    logic [LANES-1:0][7:0] ordered;
    logic [DATA_WIDTH-1:0] word;

    for (genvar k = 0; k < LANES; k++) begin : g_order

        // address byte k sits in lane (offset + k) mod 4
        assign laneSel[k] = 2'(k) + offset;
        assign ordered[k] = bytes[laneSel[k]];

    end

    assign word = ordered;

    // --------------------------------------------------
    // extension
    // --------------------------------------------------

    logic signBit8;
    logic signBit16;

    assign signBit8  = word[7];
    assign signBit16 = word[15];

    always_comb begin
        case (size)
            SIZE_W: begin
                rdata = word;
            end
            SIZE_H: begin
                rdata = {{(DATA_WIDTH-16){signBit16}}, word[15:0]};
            end
            SIZE_B: begin
                rdata = {{(DATA_WIDTH-8){signBit8}}, word[7:0]};
            end
            SIZE_HU: begin
                rdata = {{(DATA_WIDTH-16){1'b0}}, word[15:0]};
            end
            SIZE_BU: begin
                rdata = {{(DATA_WIDTH-8){1'b0}}, word[7:0]};
            end
            // undefined size code reads zero
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

// ==== design/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory (
    input  logic                              clk,
    input  dataMemPkg::memReq_t               req,
    output logic [dataMemPkg::DATA_WIDTH-1:0] rdata
);

    import dataMemPkg::*;

    // --------------------------------------------------
    // internal wiring
    // --------------------------------------------------

    // per-lane row, data and enable from the aligner
    laneWrite_t [LANES-1:0] lanes;

    // raw bytes as they come out of each bank
    logic [LANES-1:0][7:0] laneBytes;

    // --------------------------------------------------
    // store side
    // --------------------------------------------------

    storeAligner u_align (
        .req   (req),
        .lanes (lanes)
    );

    // --------------------------------------------------
    // byte lane banks
    // --------------------------------------------------

    for (genvar i = 0; i < LANES; i++) begin : g_lane

        byteBank u_bank (
            .clk   (clk),
            .lane  (lanes[i]),
            .rbyte (laneBytes[i])
        );

    end

    // --------------------------------------------------
    // load side
    // --------------------------------------------------

    // offset picks the rotation back into address order
    loadExtender u_ext (
        .bytes  (laneBytes),
        .offset (req.addr[1:0]),
        .size   (req.size),
        .rdata  (rdata)
    );

endmodule

// ==== dv/dataMemory_assertions.sv ====
`timescale 1ns/1ps

module dataMemory_assertions (
    input logic                                           clk,
    input dataMemPkg::memReq_t                            req,
    input dataMemPkg::laneWrite_t [dataMemPkg::LANES-1:0] lanes,
    input logic [dataMemPkg::DATA_WIDTH-1:0]              rdata
);

    import dataMemPkg::*;

    logic [LANES-1:0] laneEn;
    logic             storeSize;
    logic             definedSize;

    // number of property failures so far
    int failCount = 0;

    for (genvar i = 0; i < LANES; i++) begin : g_en
        assign laneEn[i] = lanes[i].en;
    end

    // only B, H and W may write
    assign storeSize   = req.size inside {SIZE_B, SIZE_H, SIZE_W};
    assign definedSize = storeSize || (req.size inside {SIZE_BU, SIZE_HU});

    // --------------------------------------------------
    // properties
    // --------------------------------------------------

    enNeedsWrite: assert property (@(posedge clk) !req.write |-> laneEn == '0)
        else begin
            failCount++;
            $error("lane enable high while write is low");
        end

    enNeedsStoreSize: assert property (@(posedge clk) !storeSize |-> laneEn == '0)
        else begin
            failCount++;
            $error("lane enable high for a size code that stores nothing");
        end

    undefinedReadsZero: assert property (@(posedge clk) !definedSize |-> rdata == '0)
        else begin
            failCount++;
            $error("rdata not zero for an undefined size code");
        end

endmodule

bind dataMemory dataMemory_assertions u_assert (
    .clk   (clk),
    .req   (req),
    .lanes (lanes),
    .rdata (rdata)
);

// ==== dv/tbDataMemory.sv ====
`timescale 1ns/1ps

module tbDataMemory;

    import dataMemPkg::*;

    // --------------------------------------------------
    // constants
    // --------------------------------------------------

    localparam string TEST_FILE     = "dv/dataMemoryTests.txt";
    localparam int    MAX_RECORDS   = 256;
    localparam int    TIMEOUT_SLACK = 50;
    localparam int    HALF_PERIOD   = 10;
    localparam int    RESET_CYCLES  = 10;

    // --------------------------------------------------
    // DUT and clock
    // --------------------------------------------------

    logic                  clk;
    logic                  rst;
    memReq_t               req;
    logic [DATA_WIDTH-1:0] rdata;

    dataMemory u_dut (
        .clk   (clk),
        .req   (req),
        .rdata (rdata)
    );

    always #(HALF_PERIOD) clk = ~clk;

    // --------------------------------------------------
    // test records
    // --------------------------------------------------

    int                    recTest   [MAX_RECORDS];
    logic                  recWrite  [MAX_RECORDS];
    logic [2:0]            recSize   [MAX_RECORDS];
    logic [ADDR_WIDTH-1:0] recAddr   [MAX_RECORDS];
    logic [DATA_WIDTH-1:0] recWdata  [MAX_RECORDS];
    logic [DATA_WIDTH-1:0] recExpect [MAX_RECORDS];

    int   numRecords;
    logic loadError;

    // per-test and overall bookkeeping
    int testChecks;
    int testErrors;
    int passedTests;
    int failedTests;
    int cycleCount;
    int cycleLimit;

    task automatic loadRecords();
        int          fd;
        int          code;
        int          num;
        string       tok;
        string       op;
        string       rest;
        logic [31:0] sizeVal;
        logic [31:0] addrVal;
        logic [31:0] wdataVal;
        logic [31:0] expVal;
        numRecords = 0;
        loadError  = 1'b0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open test file %s", TEST_FILE);
            loadError = 1'b1;
        end else begin
            while (!$feof(fd) && !loadError) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    break;
                end
                if (tok[0] == "#") begin
                    // rest of a comment line
                    code = $fgets(rest, fd);
                end else if (numRecords >= MAX_RECORDS) begin
                    $display("test file holds more than %0d records", MAX_RECORDS);
                    loadError = 1'b1;
                end else begin
                    code = $fscanf(fd, "%s %h %h %h %h", op, sizeVal, addrVal, wdataVal,
                                   expVal);
                    if (code != 5 || $sscanf(tok, "%d", num) != 1) begin
                        $display("malformed record after %0d good records", numRecords);
                        loadError = 1'b1;
                    end else if (op != "W" && op != "R") begin
                        $display("unknown op %s in test %0d", op, num);
                        loadError = 1'b1;
                    end else begin
                        recTest[numRecords]   = num;
                        recWrite[numRecords]  = (op == "W");
                        recSize[numRecords]   = sizeVal[2:0];
                        recAddr[numRecords]   = addrVal[ADDR_WIDTH-1:0];
                        recWdata[numRecords]  = wdataVal;
                        recExpect[numRecords] = expVal;
                        numRecords++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------------------------------------
    // checking and reporting
    // --------------------------------------------------

    task automatic checkLoad(input int idx);
        testChecks++;
        if (rdata !== recExpect[idx]) begin
            $display("Error at %0t: rdata expected %08h, seen %08h (test %0d, size %0d, addr %05h)",
                     $time, recExpect[idx], rdata, recTest[idx], recSize[idx], recAddr[idx]);
            testErrors++;
        end
    endtask

    task automatic reportTest(input int num);
        if (testErrors == 0) begin
            $display("test %0d passed, %0d loads checked", num, testChecks);
            passedTests++;
        end else begin
            $display("test %0d failed, %0d of %0d loads wrong", num, testErrors, testChecks);
            failedTests++;
        end
        testChecks = 0;
        testErrors = 0;
    endtask

    // one record per cycle, driven on the falling edge
    task automatic runRecords();
        int curTest;
        curTest = recTest[0];
        for (int i = 0; i < numRecords; i++) begin
            if (recTest[i] != curTest) begin
                reportTest(curTest);
                curTest = recTest[i];
            end
            @(negedge clk);
            req.addr  = recAddr[i];
            req.size  = memSize_e'(recSize[i]);
            req.wdata = recWdata[i];
            req.write = recWrite[i];
            // read path is combinational, sample mid low phase
            if (!recWrite[i]) begin
                #(HALF_PERIOD / 2);
                checkLoad(i);
            end
        end
        @(negedge clk);
        req.write = 1'b0;
        reportTest(curTest);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        req         = '0;
        testChecks  = 0;
        testErrors  = 0;
        passedTests = 0;
        failedTests = 0;
        cycleCount  = 0;
        cycleLimit  = MAX_RECORDS * 2 + TIMEOUT_SLACK;
        loadRecords();
        if (loadError || numRecords == 0) begin
            $display("no usable test records, run stopped");
            $display("TEST FAILED");
            $finish;
        end else begin
            cycleLimit = numRecords * 2 + TIMEOUT_SLACK;
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            runRecords();
            $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                     passedTests, failedTests, u_dut.u_assert.failCount);
            if (failedTests == 0 && u_dut.u_assert.failCount == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    // --------------------------------------------------
    // timeout
    // --------------------------------------------------

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// ==== list.f ====
design/dataMemPkg.sv
design/storeAligner.sv
design/byteBank.sv
design/loadExtender.sv
design/dataMemory.sv
dv/dataMemory_assertions.sv
dv/tbDataMemory.sv

// ==== dv/dataMemoryTests.txt ====
# test op size addr wdata expect (test in decimal, the rest in hex, size is funct3)
# op W stores and R loads, expect is only checked on R
1 W 2 00000 12345678 00000000
1 W 2 00004 89ABCDEF 00000000
1 W 2 1FFFC 0F1E2D3C 00000000
1 W 2 10000 A5A55A5A 00000000
1 R 2 00000 00000000 12345678
1 R 2 00004 00000000 89ABCDEF
1 R 2 1FFFC 00000000 0F1E2D3C
1 R 2 10000 00000000 A5A55A5A
2 W 2 00100 C3B2F180 00000000
2 R 0 00100 00000000 FFFFFF80
2 R 4 00100 00000000 00000080
2 R 0 00101 00000000 FFFFFFF1
2 R 4 00101 00000000 000000F1
2 R 0 00102 00000000 FFFFFFB2
2 R 0 00103 00000000 FFFFFFC3
2 R 1 00100 00000000 FFFFF180
2 R 5 00100 00000000 0000F180
2 R 1 00102 00000000 FFFFC3B2
2 R 5 00102 00000000 0000C3B2
2 R 1 00101 00000000 FFFFB2F1
2 R 5 00101 00000000 0000B2F1
2 W 2 00104 7F017F01 00000000
2 R 0 00105 00000000 0000007F
2 R 1 00104 00000000 00007F01
2 W 0 00108 123456FE 00000000
2 R 0 00108 00000000 FFFFFFFE
2 R 4 00108 00000000 000000FE
2 W 1 0010A ABCD8001 00000000
2 R 1 0010A 00000000 FFFF8001
2 R 5 0010A 00000000 00008001
3 W 2 00200 11223344 00000000
3 W 0 00201 FFFFFFAA 00000000
3 R 2 00200 00000000 1122AA44
3 W 1 00202 0000BEEF 00000000
3 R 2 00200 00000000 BEEFAA44
3 W 0 00203 00000077 00000000
3 R 2 00200 00000000 77EFAA44
3 W 2 00204 55667788 00000000
3 W 1 00203 0000C0DE 00000000
3 R 2 00200 00000000 DEEFAA44
3 R 2 00204 00000000 556677C0
3 W 0 00200 00000099 00000000
3 R 2 00200 00000000 DEEFAA99
4 W 2 00300 00000000 00000000
4 W 2 00304 00000000 00000000
4 W 2 00308 00000000 00000000
4 W 2 00301 DDCCBBAA 00000000
4 R 2 00301 00000000 DDCCBBAA
4 R 2 00300 00000000 CCBBAA00
4 R 2 00304 00000000 000000DD
4 W 2 00306 44332211 00000000
4 R 2 00306 00000000 44332211
4 R 2 00304 00000000 221100DD
4 R 2 00308 00000000 00004433
4 W 2 0030B 88776655 00000000
4 R 2 0030B 00000000 88776655
4 R 2 00308 00000000 55004433
4 R 1 0030D 00000000 FFFF8877
4 R 5 0030C 00000000 00007766
4 R 5 00307 00000000 00003322
5 W 2 00400 0BADBEEF 00000000
5 W 3 00400 CAFEF00D 00000000
5 R 2 00400 00000000 0BADBEEF
5 W 7 00400 CAFEF00D 00000000
5 W 6 00400 CAFEF00D 00000000
5 W 4 00400 CAFEF00D 00000000
5 W 5 00400 CAFEF00D 00000000
5 R 2 00400 00000000 0BADBEEF
5 R 3 00400 00000000 00000000
5 R 6 00400 00000000 00000000
5 R 7 00000 00000000 00000000
5 W 2 1FFFE 76543210 00000000
5 R 2 1FFFE 00000000 76543210
5 R 2 1FFFC 00000000 32102D3C
5 R 2 00000 00000000 12347654
5 R 1 1FFFF 00000000 00005432
5 R 5 1FFFF 00000000 00005432
5 W 0 1FFFF 000000E1 00000000
5 R 0 1FFFF 00000000 FFFFFFE1
5 R 2 1FFFE 00000000 7654E110
5 W 1 1FFFF 0000A7B6 00000000
5 R 2 1FFFC 00000000 B6102D3C
5 R 2 00000 00000000 123476A7
